/* rtl/trap_params.svh */
`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

// First fetch address out of reset
`define RESET_PC            32'h0001_0000

// Traps land on the reset address
`define TRAP_VECTOR         `RESET_PC

// mret is a single fixed encoding
`define MRET_INSN           32'h3020_0073

// Major opcodes
`define OPC_OP_IMM          7'b0010011
`define OPC_JAL             7'b1101111
`define OPC_JALR            7'b1100111

// RISC-V mcause codes
`define MCAUSE_I_MISALIGN   32'd0
`define MCAUSE_ILLEGAL      32'd2

`endif

/* rtl/trap_pkg.sv */
package trap_pkg;

    // Cause encoding handed from the exception controller to the CSRs
    typedef enum logic [1:0]
    {
        EXC_NONE       = 2'b00,
        EXC_I_MISALIGN = 2'b01,
        EXC_ILLEGAL    = 2'b10
    } exc_cause_e;

    // One instruction word, two field layouts
    typedef union packed
    {
        // I-type, used by addi and jalr
        struct packed
        {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;

        // J-type, immediate bits scattered as in the spec
        struct packed
        {
            logic        imm_20;
            logic [9:0]  imm_10_1;
            logic        imm_11;
            logic [7:0]  imm_19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j;
    } insn_u;

endpackage

/* rtl/pc_sequencer.sv */
`timescale 1ns/100ps
`include "trap_params.svh"

module pc_sequencer
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        jump_taken,
    input  logic        trap_taken,
    input  logic        mret_taken,
    input  logic [31:0] jump_target,
    input  logic [31:0] redirect_pc,
    output logic [31:0] imem_addr,
    output logic [31:0] pc_d,
    output logic        misaligned_d,
    output logic        flush_d
);

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        redirect;

    // Trap and mret outrank a jump
    // A jump decoded from a flushed word does not count
    always_comb
    begin
        redirect = 1'b1;
        if (trap_taken || mret_taken)
        begin
            next_pc = redirect_pc;
        end
        else if (jump_taken && !flush_d)
        begin
            next_pc = jump_target;
        end
        else
        begin
            next_pc  = pc + 32'd4;
            redirect = 1'b0;
        end
    end

    // Fetch PC and decode-stage flags
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc           <= `RESET_PC;
            misaligned_d <= 1'b0;
            // Word on insn right after reset is garbage
            flush_d      <= 1'b1;
        end
        else
        begin
            pc           <= next_pc;
            misaligned_d <= (pc[1:0] != 2'b00);
            flush_d      <= redirect;
        end
    end

    // PC of the word now on insn
    always_ff @(posedge clk)
    begin
        pc_d <= pc;
    end

    assign imem_addr = pc;

endmodule

/* rtl/insn_decoder.sv */
`timescale 1ns/100ps
`include "trap_params.svh"

module insn_decoder
(
    input  logic [31:0] insn,
    input  logic [31:0] pc_d,
    output logic        illegal,
    output logic        jump_taken,
    output logic        is_mret,
    output logic [31:0] jump_target
);

    trap_pkg::insn_u word;
    logic            is_addi;
    logic            is_jal;
    logic            is_jalr;
    logic [31:0]     imm_i;
    logic [31:0]     imm_j;

    assign word = insn;

    // addi is accepted but has no effect here
    assign is_addi = (word.i.opcode == `OPC_OP_IMM) && (word.i.funct3 == 3'b000);

    assign is_jal = (word.j.opcode == `OPC_JAL);

    // Only the absolute form, rs1 = x0
    assign is_jalr = (word.i.opcode == `OPC_JALR)
                  && (word.i.funct3 == 3'b000)
                  && (word.i.rs1 == 5'd0);

    assign is_mret = (insn == `MRET_INSN);

    assign illegal = !(is_addi || is_jal || is_jalr || is_mret);

    assign jump_taken = is_jal || is_jalr;

    // Sign-extended immediates
    assign imm_i = {{20{word.i.imm[11]}}, word.i.imm};

    assign imm_j = {{11{word.j.imm_20}},
                    word.j.imm_20,
                    word.j.imm_19_12,
                    word.j.imm_11,
                    word.j.imm_10_1,
                    1'b0};

    // jal is PC relative, jalr from x0 is absolute
    always_comb
    begin
        if (is_jal)
        begin
            jump_target = pc_d + imm_j;
        end
        else
        begin
            jump_target = imm_i & ~32'd1;
        end
    end

endmodule

/* rtl/exception_ctrl.sv */
`timescale 1ns/100ps
`include "trap_params.svh"

module exception_ctrl
(
    input  logic                  i_addr_misaligned,
    input  logic                  illegal_ir,
    input  logic                  jump,
    input  logic [31:0]           pc_of_i_addr_misaligned,
    input  logic [31:0]           ir_in_question,
    input  logic [31:0]           pc_of_illegal_ir,
    output trap_pkg::exc_cause_e  exception_cause,
    output logic [31:0]           exception_epc,
    output logic [31:0]           exception_tval
);

    // Word behind a pending jump never executes, so it cannot trap
    always_comb
    begin
        if (jump)
            exception_cause = trap_pkg::EXC_NONE;
        else if (illegal_ir)
            exception_cause = trap_pkg::EXC_ILLEGAL;
        else if (i_addr_misaligned)
            exception_cause = trap_pkg::EXC_I_MISALIGN;
        else
            exception_cause = trap_pkg::EXC_NONE;
    end

    // EPC and TVAL follow the chosen cause
    always_comb
    begin
        case (exception_cause)
            trap_pkg::EXC_ILLEGAL:
            begin
                exception_epc  = pc_of_illegal_ir;
                exception_tval = ir_in_question;
            end
            trap_pkg::EXC_I_MISALIGN:
            begin
                // Faulting address doubles as TVAL
                exception_epc  = pc_of_i_addr_misaligned;
                exception_tval = pc_of_i_addr_misaligned;
            end
            default:
            begin
                exception_epc  = `RESET_PC;
                exception_tval = 32'h0;
            end
        endcase
    end

endmodule

/* rtl/trap_csr.sv */
`timescale 1ns/100ps
`include "trap_params.svh"

module trap_csr
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  trap_pkg::exc_cause_e  exception_cause,
    input  logic [31:0]           exception_epc,
    input  logic [31:0]           exception_tval,
    input  logic                  is_mret,
    input  logic                  flush_d,
    output logic                  trap_taken,
    output logic                  mret_taken,
    output logic [31:0]           redirect_pc,
    output logic [31:0]           mepc,
    output logic [31:0]           mcause,
    output logic [31:0]           mtval
);

    logic [31:0] cause_code;

    assign trap_taken = (exception_cause != trap_pkg::EXC_NONE);

    // mret from a flushed word or alongside a trap is dropped
    assign mret_taken = is_mret && !flush_d && !trap_taken;

    // Only meaningful while trap_taken or mret_taken is high
    assign redirect_pc = trap_taken ? `TRAP_VECTOR : mepc;

    // Internal cause to RISC-V mcause code
    always_comb
    begin
        case (exception_cause)
            trap_pkg::EXC_ILLEGAL:    cause_code = `MCAUSE_ILLEGAL;
            trap_pkg::EXC_I_MISALIGN: cause_code = `MCAUSE_I_MISALIGN;
            default:                  cause_code = mcause;
        endcase
    end

    // Machine trap CSRs, written only on a trap
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mepc   <= 32'h0;
            mcause <= 32'h0;
            mtval  <= 32'h0;
        end
        else if (trap_taken)
        begin
            mepc   <= exception_epc;
            mcause <= cause_code;
            mtval  <= exception_tval;
        end
    end

endmodule

/* rtl/trap_core.sv */
`timescale 1ns/100ps

module trap_core
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] insn,
    output logic [31:0] imem_addr,
    output logic        trap_taken,
    output logic [31:0] mepc,
    output logic [31:0] mcause,
    output logic [31:0] mtval
);

    logic                 jump_taken;
    logic                 mret_taken;
    logic                 is_mret;
    logic                 illegal;
    logic                 misaligned_d;
    logic                 flush_d;
    logic [31:0]          pc_d;
    logic [31:0]          jump_target;
    logic [31:0]          redirect_pc;
    trap_pkg::exc_cause_e exception_cause;
    logic [31:0]          exception_epc;
    logic [31:0]          exception_tval;

    pc_sequencer pc_sequencer_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .jump_taken   (jump_taken),
        .trap_taken   (trap_taken),
        .mret_taken   (mret_taken),
        .jump_target  (jump_target),
        .redirect_pc  (redirect_pc),
        .imem_addr    (imem_addr),
        .pc_d         (pc_d),
        .misaligned_d (misaligned_d),
        .flush_d      (flush_d)
    );

    insn_decoder insn_decoder_i
    (
        .insn        (insn),
        .pc_d        (pc_d),
        .illegal     (illegal),
        .jump_taken  (jump_taken),
        .is_mret     (is_mret),
        .jump_target (jump_target)
    );

    // Flushed decode slot acts as the pending jump
    exception_ctrl exception_ctrl_i
    (
        .i_addr_misaligned       (misaligned_d),
        .illegal_ir              (illegal),
        .jump                    (flush_d),
        .pc_of_i_addr_misaligned (pc_d),
        .ir_in_question          (insn),
        .pc_of_illegal_ir        (pc_d),
        .exception_cause         (exception_cause),
        .exception_epc           (exception_epc),
        .exception_tval          (exception_tval)
    );

    trap_csr trap_csr_i
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .exception_cause (exception_cause),
        .exception_epc   (exception_epc),
        .exception_tval  (exception_tval),
        .is_mret         (is_mret),
        .flush_d         (flush_d),
        .trap_taken      (trap_taken),
        .mret_taken      (mret_taken),
        .redirect_pc     (redirect_pc),
        .mepc            (mepc),
        .mcause          (mcause),
        .mtval           (mtval)
    );

endmodule

/* test/tb_trap_core.sv */
`timescale 1ns/100ps
`include "trap_params.svh"

module tb_trap_core;

    localparam int PROG1_LEN = 12;
    localparam int PROG2_LEN = 20;
    localparam int RESET_CYCLES = 8;

    logic        clk;
    logic        rst_n;
    logic [31:0] insn;
    logic [31:0] imem_addr;
    logic        trap_taken;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;

    logic [31:0] mem [logic [31:0]];
    integer      seed;
    int          errors;
    int          addr_errors;
    int          trap_errors;
    int          csr_errors;

    // Reference state kept by the testbench
    logic [31:0] pc_d_m;
    logic        flush_m;
    logic [31:0] exp_addr_q;
    logic [31:0] exp_mepc_q;
    logic [31:0] exp_mcause_q;
    logic [31:0] exp_mtval_q;
    logic [2:0]  kind;
    logic        exp_trap;
    logic        exp_mret;
    logic        exp_jump;
    logic [31:0] exp_target;
    logic [31:0] exp_epc;
    logic [31:0] exp_tval;
    logic [31:0] exp_cause;
    logic [31:0] next_addr;

    trap_core trap_core_i
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .insn       (insn),
        .imem_addr  (imem_addr),
        .trap_taken (trap_taken),
        .mepc       (mepc),
        .mcause     (mcause),
        .mtval      (mtval)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    // 0 illegal, 1 addi, 2 jal, 3 jalr from x0, 4 mret
    function automatic logic [2:0] classify(input logic [31:0] w);
        if (w == `MRET_INSN)
            return 3'd4;
        if (w[6:0] == `OPC_OP_IMM && w[14:12] == 3'b000)
            return 3'd1;
        if (w[6:0] == `OPC_JAL)
            return 3'd2;
        if (w[6:0] == `OPC_JALR && w[14:12] == 3'b000 && w[19:15] == 5'd0)
            return 3'd3;
        return 3'd0;
    endfunction

    function automatic logic [31:0] addi_word(input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd1, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, `OPC_JAL};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [11:0] imm);
        return {imm, 5'd0, 3'b000, 5'd0, `OPC_JALR};
    endfunction

    // Unloaded addresses read an address-dependent word with opcode zero
    function automatic logic [31:0] fetch_word(input logic [31:0] a);
        if (mem.exists(a))
            return mem[a];
        return (a * 32'h9E37_79B1) & ~32'h7F;
    endfunction

    task automatic random_illegal(output logic [31:0] w);
        w = $random(seed);
        while (classify(w) != 3'd0)
        begin
            w = $random(seed);
        end
    endtask

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
        errors++;
        if (name == "imem_addr")
            addr_errors++;
        else if (name == "trap_taken")
            trap_errors++;
        else
            csr_errors++;
    endtask

    // Expected response of the decode slot
    always_comb
    begin
        kind       = classify(insn);
        exp_trap   = !flush_m && (kind == 3'd0 || pc_d_m[1:0] != 2'b00);
        exp_mret   = !flush_m && !exp_trap && kind == 3'd4;
        exp_jump   = !flush_m && !exp_trap && (kind == 3'd2 || kind == 3'd3);
        exp_cause  = (kind == 3'd0) ? `MCAUSE_ILLEGAL : `MCAUSE_I_MISALIGN;
        exp_epc    = pc_d_m;
        exp_tval   = (kind == 3'd0) ? insn : pc_d_m;
        if (kind == 3'd2)
            exp_target = pc_d_m + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
        else
            exp_target = {{20{insn[31]}}, insn[31:20]} & ~32'd1;
        if (exp_trap)
            next_addr = `TRAP_VECTOR;
        else if (exp_mret)
            next_addr = exp_mepc_q;
        else if (exp_jump)
            next_addr = exp_target;
        else
            next_addr = exp_addr_q + 32'd4;
    end

    // Instruction memory with one cycle of latency, plus reference registers
    always @(posedge clk)
    begin
        insn   <= fetch_word(imem_addr);
        pc_d_m <= exp_addr_q;
        if (!rst_n)
        begin
            flush_m      <= 1'b1;
            exp_addr_q   <= `RESET_PC;
            exp_mepc_q   <= 32'h0;
            exp_mcause_q <= 32'h0;
            exp_mtval_q  <= 32'h0;
        end
        else
        begin
            flush_m    <= exp_trap || exp_mret || exp_jump;
            exp_addr_q <= next_addr;
            if (exp_trap)
            begin
                exp_mepc_q   <= exp_epc;
                exp_mcause_q <= exp_cause;
                exp_mtval_q  <= exp_tval;
            end
        end
    end

    a_addr: assert property (@(posedge clk) disable iff (!rst_n) imem_addr == exp_addr_q)
        else report("imem_addr", $sampled(imem_addr), $sampled(exp_addr_q));
    a_trap: assert property (@(posedge clk) disable iff (!rst_n) trap_taken == exp_trap)
        else report("trap_taken", {31'd0, $sampled(trap_taken)}, {31'd0, $sampled(exp_trap)});
    a_mepc: assert property (@(posedge clk) disable iff (!rst_n) mepc == exp_mepc_q)
        else report("mepc", $sampled(mepc), $sampled(exp_mepc_q));
    a_mcause: assert property (@(posedge clk) disable iff (!rst_n) mcause == exp_mcause_q)
        else report("mcause", $sampled(mcause), $sampled(exp_mcause_q));
    a_mtval: assert property (@(posedge clk) disable iff (!rst_n) mtval == exp_mtval_q)
        else report("mtval", $sampled(mtval), $sampled(exp_mtval_q));

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_traps(input int n);
        int count;
        count = 0;
        while (count < n)
        begin
            @(negedge clk);
            if (trap_taken)
                count++;
        end
        repeat (2) @(negedge clk);
    endtask

    // Two addi, jalr to 0x100, addi, then an illegal word
    task automatic load_jalr_program();
        logic [31:0] w;
        mem.delete();
        mem[`RESET_PC]         = addi_word(12'h005);
        mem[`RESET_PC + 32'h4] = addi_word(12'h7ff);
        mem[`RESET_PC + 32'h8] = jalr_word(12'h101);
        mem[32'h100]           = addi_word(12'h010);
        random_illegal(w);
        mem[32'h104] = w;
    endtask

    // mret from reset, jal to a misaligned target, flushed illegal words
    task automatic load_misalign_program();
        logic [31:0] w;
        mem.delete();
        mem[`RESET_PC] = `MRET_INSN;
        random_illegal(w);
        mem[`RESET_PC + 32'h4] = w;
        mem[32'h0] = addi_word(12'h001);
        mem[32'h4] = jal_word(21'h1e);
        random_illegal(w);
        mem[32'h8] = w;
        mem[32'h22] = addi_word(12'h002);
        random_illegal(w);
        mem[32'h26] = w;
    endtask

    initial
    begin
        rst_n       = 1'b0;
        insn        = 32'h0;
        seed        = 85;
        errors      = 0;
        addr_errors = 0;
        trap_errors = 0;
        csr_errors  = 0;

        load_jalr_program();
        apply_reset();
        wait_traps(1);

        load_misalign_program();
        apply_reset();
        wait_traps(2);

        $display("Errors: %0d total, %0d imem_addr, %0d trap_taken, %0d CSR",
                 errors, addr_errors, trap_errors, csr_errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #((PROG1_LEN + PROG2_LEN) * 40 + 2 * RESET_CYCLES * 20);
        $display("Timeout: the expected traps never arrived");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* trap_core.f */
+incdir+rtl
rtl/trap_pkg.sv
rtl/pc_sequencer.sv
rtl/insn_decoder.sv
rtl/exception_ctrl.sv
rtl/trap_csr.sv
rtl/trap_core.sv
test/tb_trap_core.sv

/* Makefile */
SRCS = $(shell grep -v '^+' trap_core.f) rtl/trap_params.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_trap_core: $(SRCS) trap_core.f
	verilator --binary --timing --assert -Wno-fatal -f trap_core.f --top-module tb_trap_core

run: obj_dir/Vtb_trap_core
	./obj_dir/Vtb_trap_core | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
